// File: Makefile
TOOL     := verilator
TOP      := mul_unit_tb
FILELIST := files.f
BUILD    := obj_dir
FLAGS    := --binary --timing -Wno-fatal --top-module $(TOP)
PASS_MSG := Simulation finished: PASS

SOURCES  := $(shell cat $(FILELIST))
SIM      := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

// File: files.f
verilog/mul_pkg.sv
verilog/mul_operand_queue.sv
verilog/mul_core.sv
verilog/mul_writeback.sv
verilog/mul_unit_top.sv
test/mul_unit_tb.sv

// File: test/mul_cases.txt
// funct op_a op_b expected, all hex
// funct 0 MUL, 1 MULH, 2 MULHSU, 3 MULHU
0 00000003 00000007 00000015
1 80000000 80000000 40000000
0 FFFFFFFF 00000005 FFFFFFFB
2 80000000 FFFFFFFF 80000000
3 FFFFFFFF FFFFFFFF FFFFFFFE
0 FFFFFFFE FFFFFFFD 00000006
1 80000000 7FFFFFFF C0000000
1 FFFFFFFF FFFFFFFF 00000000
0 80000000 FFFFFFFF 80000000
2 FFFFFFFF FFFFFFFF FFFFFFFF
3 80000000 80000000 40000000
0 7FFFFFFF 7FFFFFFF 00000001
1 7FFFFFFF 7FFFFFFF 3FFFFFFF
2 7FFFFFFF FFFFFFFF 7FFFFFFE
3 80000000 FFFFFFFF 7FFFFFFF
0 12345678 00010000 56780000
1 FFFFFFFF 00000001 FFFFFFFF
1 00000000 80000000 00000000
2 00000002 80000000 00000001
3 7FFFFFFF 00000002 00000000
0 0000FFFF 0000FFFF FFFE0001
1 80000000 FFFFFFFF 00000000
1 FFFF0000 00010000 FFFFFFFF
2 FFFFFFFE 80000000 FFFFFFFF
3 00010000 00010000 00000001
0 00000000 DEADBEEF 00000000
1 12345678 FFFFFFFE FFFFFFFF
1 7FFFFFFF FFFFFFFF FFFFFFFF
2 00000000 FFFFFFFF 00000000
3 FFFF0000 00010000 0000FFFF

// File: test/mul_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mul_unit_tb import mul_pkg::*; ();

  localparam int MAX_CASES    = 64;
  localparam int IDLE_CYCLES  = 5;
  localparam int DRAIN_CYCLES = 8;

  logic     clk;
  logic     rst_n;
  logic     req_valid;
  mul_req_t req;
  logic     req_credit;
  mul_rsp_t rsp;
  logic     rsp_valid;
  logic     rsp_credit;

  // Four words per case: funct, op_a, op_b, expected result
  logic [31:0] case_mem [MAX_CASES*4];
  int          num_cases;
  int          next_case;
  int          rsp_count;
  // Credits held by the driver, and responses not yet paid back
  int          req_credits;
  int          rsp_outstanding;
  int          cycle_count;
  int          cycle_limit;
  int          seed;
  // Case indices in request order
  int          expect_q [$];
  // Remaining wait before each pending response credit goes back
  int          credit_delay_q [$];

  mul_unit_top mul_unit_top_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid),
    .req_i        (req),
    .req_credit_o (req_credit),
    .rsp_o        (rsp),
    .rsp_valid_o  (rsp_valid),
    .rsp_credit_i (rsp_credit)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_rsp_tag(input string name, input logic [MUL_TAG_W-1:0] exp_tag,
                               input logic [MUL_TAG_W-1:0] act_tag);
    if (act_tag !== exp_tag) begin
      stop_on_error($sformatf("CHECK FAILED %s tag: expected 0x%h, actual 0x%h",
                              name, exp_tag, act_tag));
    end
  endtask

  task automatic check_result(input string name, input logic [31:0] exp_res,
                              input logic [31:0] act_res);
    if (act_res !== exp_res) begin
      stop_on_error($sformatf("CHECK FAILED %s result: expected 0x%h, actual 0x%h",
                              name, exp_res, act_res));
    end
  endtask

  function automatic string funct_name(input int idx);
    mul_funct_e funct;
    funct = mul_funct_e'(case_mem[idx*4][1:0]);
    return funct.name();
  endfunction

  ////////////////////////////////////////////////////////////
  // Per cycle work, outputs first, then new inputs
  ////////////////////////////////////////////////////////////

  task automatic observe_outputs();
    int    idx;
    string name;
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      stop_on_error($sformatf("Timeout after %0d cycles, %0d of %0d responses received",
                              cycle_count, rsp_count, num_cases));
    end
    // Quiet outputs until the first request goes in
    if (next_case == 0 && (rsp_valid || req_credit)) begin
      stop_on_error("Response or request credit appeared before the first request");
    end
    if (req_credit) begin
      req_credits++;
      if (req_credits > MUL_QUEUE_DEPTH) begin
        stop_on_error("More request credits came back than were spent");
      end
    end
    // Age pending response credits
    for (int i = 0; i < credit_delay_q.size(); i++) begin
      if (credit_delay_q[i] > 0) begin
        credit_delay_q[i]--;
      end
    end
    if (rsp_valid) begin
      if (expect_q.size() == 0) begin
        stop_on_error("Response arrived with no request outstanding");
      end
      if (rsp_outstanding >= MUL_RSP_CREDITS) begin
        stop_on_error("Response arrived while the unit held no response credit");
      end
      idx  = expect_q.pop_front();
      name = $sformatf("case %0d %s", idx, funct_name(idx));
      check_rsp_tag(name, MUL_TAG_W'(idx % 16), rsp.tag);
      check_result(name, case_mem[idx*4+3], rsp.result);
      rsp_outstanding++;
      rsp_count++;
      // Credit goes back 0 to 3 cycles later
      credit_delay_q.push_back($random(seed) & 3);
    end
  endtask

  task automatic drive_inputs();
    // At most one response credit pulse per cycle
    rsp_credit = 1'b0;
    if (credit_delay_q.size() > 0 && credit_delay_q[0] == 0) begin
      void'(credit_delay_q.pop_front());
      rsp_credit = 1'b1;
      rsp_outstanding--;
    end
    req_valid = 1'b0;
    req       = '0;
    // Back to back while credits last
    if (next_case < num_cases && req_credits > 0) begin
      req_valid = 1'b1;
      req.funct = mul_funct_e'(case_mem[next_case*4][1:0]);
      req.op_a  = case_mem[next_case*4+1];
      req.op_b  = case_mem[next_case*4+2];
      req.tag   = MUL_TAG_W'(next_case % 16);
      req_credits--;
      expect_q.push_back(next_case);
      next_case++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int i;
    rst_n           = 1'b0;
    req_valid       = 1'b0;
    req             = '0;
    rsp_credit      = 1'b0;
    seed            = 46840;
    next_case       = 0;
    rsp_count       = 0;
    req_credits     = MUL_QUEUE_DEPTH;
    rsp_outstanding = 0;
    cycle_count     = 0;
    // Funct slot of an unused case reads far above 3
    for (i = 0; i < MAX_CASES*4; i++) begin
      case_mem[i] = {16'hFFFF, i[15:0]};
    end
    $readmemh("test/mul_cases.txt", case_mem);
    num_cases = 0;
    while (num_cases < MAX_CASES && case_mem[num_cases*4] < 32'd4) begin
      num_cases++;
    end
    if (num_cases == 0) begin
      stop_on_error("No cases were loaded from test/mul_cases.txt");
    end
    cycle_limit = 20 * num_cases + 100;

    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    // Idle window after reset
    repeat (IDLE_CYCLES) begin
      @(negedge clk);
      observe_outputs();
    end
    while (rsp_count < num_cases) begin
      @(negedge clk);
      observe_outputs();
      drive_inputs();
    end
    // Let the last credits settle
    repeat (DRAIN_CYCLES) begin
      @(negedge clk);
      observe_outputs();
      drive_inputs();
    end

    if (req_credits != MUL_QUEUE_DEPTH) begin
      stop_on_error($sformatf("Request credits ended at %0d instead of %0d",
                              req_credits, MUL_QUEUE_DEPTH));
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: verilog/mul_core.sv
`timescale 1ns/1ps
`default_nettype none

module mul_core import mul_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  // Head entry from the queue, stable until done
  input  mul_issue_t issue_i,
  input  logic       issue_valid_i,
  // Result towards writeback
  output mul_rsp_t   result_o,
  output logic       result_valid_o,
  input  logic       wb_ready_i,
  output logic       done_o
);

  ////////////////////////////////////////////////////////////
  // Subword multiplier
  ////////////////////////////////////////////////////////////

  logic [16:0] sub_op_a;
  logic [16:0] sub_op_b;
  logic [32:0] sub_corr;
  logic [33:0] sub_mul;
  logic [33:0] sub_mac;
  logic [33:0] sub_result;

  logic [4:0]  step_imm;
  logic [1:0]  step_subword;
  logic [1:0]  step_signed;
  logic        step_arith;
  logic        step_save;
  logic        step_clear;
  logic        psum_load;

  mult_state_e state_q;
  mult_state_e state_d;
  logic        carry_q;
  logic [31:0] psum_q;
  logic [31:0] int_result;

  // Half select, bit 0 picks A high, bit 1 picks B high
  assign sub_op_a[15:0] = step_subword[0] ? issue_i.op_a[31:16] : issue_i.op_a[15:0];
  assign sub_op_b[15:0] = step_subword[1] ? issue_i.op_b[31:16] : issue_i.op_b[15:0];
  // Sign extension only for a signed upper half
  assign sub_op_a[16]   = step_signed[0] & sub_op_a[15];
  assign sub_op_b[16]   = step_signed[1] & sub_op_b[15];

  // Correction term, nothing to add on the first step
  assign sub_corr   = (state_q == STEP0) ? '0 : {carry_q, psum_q};

  assign sub_mul    = $signed(sub_op_a) * $signed(sub_op_b);
  assign sub_mac    = $signed(sub_corr) + $signed(sub_mul);
  // Top two bits only kept as sign when the step is arithmetic
  assign sub_result = $signed({step_arith & sub_mac[33], step_arith & sub_mac[32],
                               sub_mac[31:0]}) >>> step_imm;

  ////////////////////////////////////////////////////////////
  // Step machine
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    step_imm       = 5'd0;
    step_subword   = 2'b00;
    step_signed    = 2'b00;
    step_arith     = 1'b0;
    step_save      = 1'b0;
    step_clear     = 1'b0;
    psum_load      = 1'b0;
    result_valid_o = 1'b0;
    case (state_q)
      IDLE_MULT: begin
        // Low product is ready straight away
        if (issue_valid_i) begin
          if (issue_i.opcode == MUL_M32) begin
            result_valid_o = 1'b1;
          end else begin
            state_d = STEP0;
          end
        end
      end
      STEP0: begin
        // AL*BL, unsigned and never overflows
        step_imm  = 5'd16;
        psum_load = 1'b1;
        state_d   = STEP1;
      end
      STEP1: begin
        // AL*BH, signed by B, carry kept as the 33rd bit
        step_signed  = {issue_i.op_signed[1], 1'b0};
        step_subword = 2'b10;
        step_arith   = 1'b1;
        step_save    = 1'b1;
        psum_load    = 1'b1;
        state_d      = STEP2;
      end
      STEP2: begin
        // AH*BL, signed by A
        step_signed  = {1'b0, issue_i.op_signed[0]};
        step_subword = 2'b01;
        step_imm     = 5'd16;
        step_arith   = 1'b1;
        // Upper bits shift back in, carry no longer needed
        step_save    = 1'b1;
        step_clear   = 1'b1;
        psum_load    = 1'b1;
        state_d      = FINISH;
      end
      FINISH: begin
        // AH*BH, held until writeback has a credit
        step_signed    = issue_i.op_signed;
        step_subword   = 2'b11;
        result_valid_o = 1'b1;
        if (wb_ready_i) begin
          state_d = IDLE_MULT;
        end
      end
      default: begin
        state_d = IDLE_MULT;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE_MULT;
      carry_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (step_save) begin
        carry_q <= ~step_clear & sub_mac[32];
      end else if (done_o) begin
        carry_q <= 1'b0;
      end
    end
  end

  // Running partial sum between steps
  always_ff @(posedge clk) begin
    if (psum_load) begin
      psum_q <= sub_result[31:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////

  // Low word is the same for any operand signedness
  assign int_result = $signed(issue_i.op_a) * $signed(issue_i.op_b);

  always_comb begin
    result_o.tag = issue_i.tag;
    if (issue_i.opcode == MUL_M32) begin
      result_o.result = int_result;
    end else begin
      result_o.result = sub_result[31:0];
    end
  end

  // Handoff to writeback retires the head
  assign done_o = result_valid_o & wb_ready_i;

endmodule

`default_nettype wire

// File: verilog/mul_operand_queue.sv
`timescale 1ns/1ps
`default_nettype none

module mul_operand_queue import mul_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  // Request side, credit based
  input  logic       req_valid_i,
  input  mul_req_t   req_i,
  output logic       req_credit_o,
  // Head entry towards the core
  output mul_issue_t issue_o,
  output logic       issue_valid_o,
  input  logic       done_i
);

  mul_req_t                   mem_q [MUL_QUEUE_DEPTH];
  logic [MUL_QUEUE_PTR_W-1:0] wr_ptr_q;
  logic [MUL_QUEUE_PTR_W-1:0] rd_ptr_q;
  logic [MUL_CREDIT_W-1:0]    count_q;
  logic                       push;
  logic                       pop;
  mul_req_t                   head;

  // Upstream holds credits, full check only guards the storage
  assign push = req_valid_i && (count_q != MUL_CREDIT_W'(MUL_QUEUE_DEPTH));
  // Core signals done only while the head is valid
  assign pop  = done_i && (count_q != '0);

  // Circular pointer advance
  function automatic logic [MUL_QUEUE_PTR_W-1:0] ptr_next(
    input logic [MUL_QUEUE_PTR_W-1:0] ptr
  );
    if (ptr == MUL_QUEUE_PTR_W'(MUL_QUEUE_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= req_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      count_q      <= '0;
      req_credit_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // One credit back per retired entry
      req_credit_o <= pop;
    end
  end

  ////////////////////////////////////////////////////////////
  // Head decode
  ////////////////////////////////////////////////////////////

  assign head          = mem_q[rd_ptr_q];
  assign issue_valid_o = (count_q != '0);

  always_comb begin
    issue_o.op_a = head.op_a;
    issue_o.op_b = head.op_b;
    issue_o.tag  = head.tag;
    case (head.funct)
      MUL: begin
        issue_o.opcode    = MUL_M32;
        issue_o.op_signed = 2'b00;
      end
      MULH: begin
        issue_o.opcode    = MUL_H;
        issue_o.op_signed = 2'b11;
      end
      // A signed, B unsigned
      MULHSU: begin
        issue_o.opcode    = MUL_H;
        issue_o.op_signed = 2'b01;
      end
      default: begin
        issue_o.opcode    = MUL_H;
        issue_o.op_signed = 2'b00;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/mul_pkg.sv
`default_nettype none

package mul_pkg;

  ////////////////////////////////////////////////////////////
  // Sizing
  ////////////////////////////////////////////////////////////

  // Response tag width
  localparam int unsigned MUL_TAG_W       = 4;
  // Operand queue depth, also the upstream credit count after reset
  localparam int unsigned MUL_QUEUE_DEPTH = 4;
  localparam int unsigned MUL_QUEUE_PTR_W = $clog2(MUL_QUEUE_DEPTH);
  // Response credits owned by the unit after reset
  localparam int unsigned MUL_RSP_CREDITS = 2;
  // Wide enough for a full queue count and the credit counter
  localparam int unsigned MUL_CREDIT_W    = 3;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  // External function code, low bits of the RISC-V funct3
  typedef enum logic [1:0] {
    MUL    = 2'd0,
    MULH   = 2'd1,
    MULHSU = 2'd2,
    MULHU  = 2'd3
  } mul_funct_e;

  // Internal opcode seen by the core
  typedef enum logic {
    MUL_M32 = 1'b0,
    MUL_H   = 1'b1
  } mul_opcode_e;

  // High product step machine
  typedef enum logic [2:0] {
    IDLE_MULT = 3'd0,
    STEP0     = 3'd1,
    STEP1     = 3'd2,
    STEP2     = 3'd3,
    FINISH    = 3'd4
  } mult_state_e;

  ////////////////////////////////////////////////////////////
  // Payloads
  ////////////////////////////////////////////////////////////

  // Request from outside, 70 bits
  typedef struct packed {
    mul_funct_e           funct;
    logic [31:0]          op_a;
    logic [31:0]          op_b;
    logic [MUL_TAG_W-1:0] tag;
  } mul_req_t;

  // Decoded head entry, 71 bits
  typedef struct packed {
    mul_opcode_e          opcode;
    logic [1:0]           op_signed;  // bit 0 for A, bit 1 for B
    logic [31:0]          op_a;
    logic [31:0]          op_b;
    logic [MUL_TAG_W-1:0] tag;
  } mul_issue_t;

  // Response to outside, 36 bits
  typedef struct packed {
    logic [MUL_TAG_W-1:0] tag;
    logic [31:0]          result;
  } mul_rsp_t;

endpackage

`default_nettype wire

// File: verilog/mul_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module mul_unit_top import mul_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  // Requests in
  input  logic     req_valid_i,
  input  mul_req_t req_i,
  output logic     req_credit_o,
  // Responses out
  output mul_rsp_t rsp_o,
  output logic     rsp_valid_o,
  input  logic     rsp_credit_i
);

  // Queue to core
  mul_issue_t issue;
  logic       issue_valid;
  logic       done;
  // Core to writeback
  mul_rsp_t   result;
  logic       result_valid;
  logic       wb_ready;

  mul_operand_queue mul_operand_queue_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .req_credit_o  (req_credit_o),
    .issue_o       (issue),
    .issue_valid_o (issue_valid),
    .done_i        (done)
  );

  mul_core mul_core_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .issue_i        (issue),
    .issue_valid_i  (issue_valid),
    .result_o       (result),
    .result_valid_o (result_valid),
    .wb_ready_i     (wb_ready),
    .done_o         (done)
  );

  mul_writeback mul_writeback_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .result_i       (result),
    .result_valid_i (result_valid),
    .wb_ready_o     (wb_ready),
    .rsp_o          (rsp_o),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_credit_i   (rsp_credit_i)
  );

endmodule

`default_nettype wire

// File: verilog/mul_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module mul_writeback import mul_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  // From the core
  input  mul_rsp_t result_i,
  input  logic     result_valid_i,
  output logic     wb_ready_o,
  // Response side, credit based
  output mul_rsp_t rsp_o,
  output logic     rsp_valid_o,
  input  logic     rsp_credit_i
);

  logic [MUL_CREDIT_W-1:0] credit_q;
  logic                    handoff;

  // Accept only while a response credit is left
  assign wb_ready_o = (credit_q != '0);
  assign handoff    = result_valid_i && wb_ready_o;

  ////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (handoff) begin
      rsp_o <= result_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid_o <= 1'b0;
    end else begin
      // One cycle pulse per response
      rsp_valid_o <= handoff;
    end
  end

  ////////////////////////////////////////////////////////////
  // Response credits
  ////////////////////////////////////////////////////////////

  // Spent at handoff, one per rsp_valid_o pulse that follows
  // so back to back handoffs never overdraw
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_q <= MUL_CREDIT_W'(MUL_RSP_CREDITS);
    end else begin
      case ({handoff, rsp_credit_i})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

endmodule

`default_nettype wire
